// ==== source/core_config.svh ====
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

`define DATA_W     16    // Datapath width
`define INSN_W     16    // Instruction word width
`define REG_IDX_W  4     // Register index width
`define NUM_REGS   16
`define PC_W       8     // Instruction address width
`define OPC_W      4

// Opcodes, anything not listed executes as NOP
`define OP_NOP     4'd0
`define OP_MOVI    4'd1  // rd = zero-extended imm8
`define OP_ADD     4'd2
`define OP_SUB     4'd3  // Wraps modulo 2**16
`define OP_AND     4'd4
`define OP_OR      4'd5
`define OP_XOR     4'd6
`define OP_JMP     4'd7  // pc = imm8, no register write

`endif

// ==== source/core_pkg.sv ====
`include "core_config.svh"

package core_pkg;

	typedef logic [`DATA_W-1:0]    data_t;    // Register and ALU word
	typedef logic [`INSN_W-1:0]    insn_t;    // Raw instruction word
	typedef logic [`REG_IDX_W-1:0] reg_idx_t; // rd, rs, rt
	typedef logic [`PC_W-1:0]      pc_t;      // Instruction memory address
	typedef logic [`OPC_W-1:0]     opcode_t;

	// Immediate field, low byte of the instruction
	typedef logic [7:0]            imm_t;

endpackage

// ==== source/core_ifs.sv ====
`timescale 1ns/10ps

// Decode to execute pipeline register contents
interface issue_if import core_pkg::*; ();
	logic     valid;  // Low for a bubble
	opcode_t  opcode;
	reg_idx_t rd;
	reg_idx_t rs;
	reg_idx_t rt;
	data_t    op_a;   // Register file value of rs
	data_t    op_b;   // Register file value of rt
	imm_t     imm;

	modport producer (
		output valid, opcode, rd, rs, rt, op_a, op_b, imm
	);

	modport consumer (
		input valid, opcode, rd, rs, rt, op_a, op_b, imm
	);
endinterface

// Two combinational read ports of the register file
interface rf_read_if import core_pkg::*; ();
	reg_idx_t rs_idx;
	reg_idx_t rt_idx;
	data_t    rs_data;
	data_t    rt_data;

	modport reader (
		output rs_idx, rt_idx,
		input  rs_data, rt_data
	);

	modport regs (
		input  rs_idx, rt_idx,
		output rs_data, rt_data
	);
endinterface

// ==== source/fetch_stage.sv ====
`timescale 1ns/10ps

module fetch_stage import core_pkg::*; (
	input  logic clk,
	input  logic arst_n,
	input  logic redirect,     // Taken jump from execute
	input  pc_t  redirect_pc,
	output pc_t  imem_addr,
	output logic insn_valid    // Qualifies the word now arriving from memory
);

	pc_t pc;

	assign imem_addr = pc;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc <= '0;
		end else if (redirect) begin
			pc <= redirect_pc;
		end else begin
			pc <= pc + 1'b1;       // Wraps at 256
		end
	end

	// The memory answers one cycle late, so the valid bit trails the pc.
	// Nothing was addressed before reset, and the address presented during
	// a redirect cycle is on the flushed path.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			insn_valid <= 1'b0;
		end else begin
			insn_valid <= !redirect;
		end
	end

endmodule

// ==== source/decode_stage.sv ====
`timescale 1ns/10ps

module decode_stage import core_pkg::*; (
	input  logic      clk,
	input  logic      arst_n,
	input  insn_t     insn,        // Word from instruction memory
	input  logic      insn_valid,
	input  logic      redirect,    // Flush the word decoded this cycle
	rf_read_if.reader rf,
	issue_if.producer iss
);

	opcode_t  opcode;
	reg_idx_t rd;
	reg_idx_t rs;
	reg_idx_t rt;
	imm_t     imm;

	// Fields: opcode 15:12, rd 11:8, rs 7:4, rt 3:0, imm8 7:0
	assign opcode = insn[15:12];
	assign rd     = insn[11:8];
	assign rs     = insn[7:4];
	assign rt     = insn[3:0];
	assign imm    = insn[7:0];

	assign rf.rs_idx = rs;       // Read ports follow the raw fields
	assign rf.rt_idx = rt;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			iss.valid <= 1'b0;
		end else begin
			iss.valid <= insn_valid && !redirect;  // Jump shadow becomes a bubble
		end
	end

	always_ff @(posedge clk) begin
		iss.opcode <= opcode;
		iss.rd     <= rd;
		iss.rs     <= rs;
		iss.rt     <= rt;
		iss.imm    <= imm;
		iss.op_a   <= rf.rs_data;  // Includes write-through from writeback
		iss.op_b   <= rf.rt_data;
	end

	// Bubbles must stay clean or wb_valid and redirect go unknown downstream
	a_iss_valid_known: assert property (
		@(posedge clk) disable iff (!arst_n)
		!$isunknown(iss.valid)
	) else $error("decode: issue valid is unknown");

endmodule

// ==== source/reg_file.sv ====
`timescale 1ns/10ps

`include "core_config.svh"

module reg_file import core_pkg::*; (
	input  logic     clk,
	input  logic     arst_n,
	input  logic     we,       // Writeback strobe
	input  reg_idx_t wreg,
	input  data_t    wdata,
	rf_read_if.regs  rf
);

	data_t regs [`NUM_REGS];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < `NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[wreg] <= wdata;
		end
	end

	// Write-through covers the distance-two dependency
	assign rf.rs_data = (we && wreg == rf.rs_idx) ? wdata : regs[rf.rs_idx];
	assign rf.rt_data = (we && wreg == rf.rt_idx) ? wdata : regs[rf.rt_idx];

	a_write_known: assert property (
		@(posedge clk) disable iff (!arst_n)
		we |-> !$isunknown({wreg, wdata})
	) else $error("reg_file: write with unknown index or data");

endmodule

// ==== source/execute_stage.sv ====
`timescale 1ns/10ps

`include "core_config.svh"

module execute_stage import core_pkg::*; (
	input  logic       clk,
	input  logic       arst_n,
	issue_if.consumer  iss,
	output logic       redirect,     // Single-cycle strobe to fetch and decode
	output pc_t        redirect_pc,
	output logic       wb_valid,
	output reg_idx_t   wb_reg,
	output data_t      wb_data
);

	data_t src_a;
	data_t src_b;
	data_t alu_res;
	logic  alu_we;                   // Opcode writes rd

	// Distance-one forwarding from the result register
	assign src_a = (wb_valid && wb_reg == iss.rs) ? wb_data : iss.op_a;
	assign src_b = (wb_valid && wb_reg == iss.rt) ? wb_data : iss.op_b;

	always_comb begin
		alu_res = '0;
		alu_we  = 1'b1;
		case (iss.opcode)
			`OP_MOVI: alu_res = data_t'(iss.imm);  // Zero extend
			`OP_ADD:  alu_res = src_a + src_b;
			`OP_SUB:  alu_res = src_a - src_b;
			`OP_AND:  alu_res = src_a & src_b;
			`OP_OR:   alu_res = src_a | src_b;
			`OP_XOR:  alu_res = src_a ^ src_b;
			default: begin                         // NOP, JMP, unused codes
				alu_we = 1'b0;
			end
		endcase
	end

	assign redirect    = iss.valid && iss.opcode == `OP_JMP;
	assign redirect_pc = iss.imm;    // Absolute target

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wb_valid <= 1'b0;
		end else begin
			wb_valid <= iss.valid && alu_we;
		end
	end

	always_ff @(posedge clk) begin
		wb_reg  <= iss.rd;
		wb_data <= alu_res;
	end

	// A jump leaves a bubble behind it, so redirect never holds for two cycles
	a_redirect_strobe: assert property (
		@(posedge clk) disable iff (!arst_n)
		redirect |=> !redirect
	) else $error("execute: redirect held longer than one cycle");

endmodule

// ==== source/tiny_core.sv ====
`timescale 1ns/10ps

module tiny_core import core_pkg::*; (
	input  logic     clk,
	input  logic     arst_n,
	output pc_t      imem_addr,
	input  insn_t    imem_data,   // Arrives one cycle after imem_addr
	output logic     wb_valid,
	output reg_idx_t wb_reg,
	output data_t    wb_data
);

	issue_if   iss_bus ();
	rf_read_if rf_bus ();

	logic redirect;
	pc_t  redirect_pc;
	logic insn_valid;

	fetch_stage fetch_inst (
		.clk         (clk),
		.arst_n      (arst_n),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.imem_addr   (imem_addr),
		.insn_valid  (insn_valid)
	);

	decode_stage decode_inst (
		.clk        (clk),
		.arst_n     (arst_n),
		.insn       (imem_data),
		.insn_valid (insn_valid),
		.redirect   (redirect),
		.rf         (rf_bus.reader),
		.iss        (iss_bus.producer)
	);

	reg_file reg_file_inst (
		.clk    (clk),
		.arst_n (arst_n),
		.we     (wb_valid),          // Result register writes back directly
		.wreg   (wb_reg),
		.wdata  (wb_data),
		.rf     (rf_bus.regs)
	);

	execute_stage execute_inst (
		.clk         (clk),
		.arst_n      (arst_n),
		.iss         (iss_bus.consumer),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.wb_valid    (wb_valid),
		.wb_reg      (wb_reg),
		.wb_data     (wb_data)
	);

endmodule

// ==== sim/core_checker.sv ====
`timescale 1ns/10ps

module core_checker import core_pkg::*; (
	input  logic     clk,
	input  logic     arst_n,
	input  pc_t      imem_addr,
	input  logic     wb_valid,
	input  reg_idx_t wb_reg,
	input  data_t    wb_data
);

	string    exp_name [$];     // Expected writes in program order
	reg_idx_t exp_reg  [$];
	data_t    exp_val  [$];
	int       errors      = 0;
	int       write_count = 0;
	logic     was_reset   = 1'b1;

	task automatic expect_write(input string name, input reg_idx_t r, input data_t v);
		exp_name.push_back(name);
		exp_reg.push_back(r);
		exp_val.push_back(v);
	endtask

	task automatic report_missing();
		while (exp_name.size() > 0) begin
			$display("Missing write for %s: r%0d was never written", exp_name[0], exp_reg[0]);
			errors++;
			void'(exp_name.pop_front());
			void'(exp_reg.pop_front());
			void'(exp_val.pop_front());
		end
	endtask

	// Sampled mid-cycle, away from the rising edge
	always @(negedge clk) begin
		if (!arst_n) begin
			if (wb_valid !== 1'b0 || imem_addr !== '0) begin
				$display("Reset check failed: wb_valid or imem_addr is not idle during reset");
				errors++;
			end
		end else begin
			if (was_reset && (wb_valid !== 1'b0 || imem_addr !== 8'd1)) begin
				$display("Reset check failed: first cycle after reset is not a clean fetch");
				errors++;
			end
			if (wb_valid === 1'b1) begin
				write_count++;
				if (exp_name.size() == 0) begin
					$display("Unexpected write: r%0d = 0x%04h after all expected writes",
						wb_reg, wb_data);
					errors++;
				end else begin
					if (wb_reg !== exp_reg[0] || wb_data !== exp_val[0]) begin
						$display("ERROR %s: expected r%0d = 0x%04h, actual r%0d = 0x%04h",
							exp_name[0], exp_reg[0], exp_val[0], wb_reg, wb_data);
						errors++;
					end
					void'(exp_name.pop_front());
					void'(exp_reg.pop_front());
					void'(exp_val.pop_front());
				end
			end else if (wb_valid !== 1'b0) begin
				$display("Writeback strobe is unknown after reset");
				errors++;
			end
		end
		was_reset = !arst_n;
	end

endmodule

// ==== sim/tb_core.sv ====
`timescale 1ns/10ps

`include "core_config.svh"

module tb_core import core_pkg::*; ();

	logic     clk       = 1'b0;
	logic     arst_n    = 1'b0;
	pc_t      imem_addr;
	insn_t    imem_data = '0;
	logic     wb_valid;
	reg_idx_t wb_reg;
	data_t    wb_data;

	insn_t    rom [256];

	// Program table, one entry per instruction address
	string    t_name    [32];
	insn_t    t_insn    [32];
	logic     t_writes  [32];
	reg_idx_t t_exp_reg [32];
	data_t    t_exp_val [32];

	data_t    model_regs [16];     // Reference register file
	int       n_entries = 0;
	int       n_writes  = 0;
	integer   seed;
	bit       timed_out = 1'b0;

	always #20 clk = ~clk;

	always @(posedge clk) begin
		imem_data <= rom[imem_addr];   // Synchronous ROM, one cycle latency
	end

	tiny_core tiny_core_inst (
		.clk       (clk),
		.arst_n    (arst_n),
		.imem_addr (imem_addr),
		.imem_data (imem_data),
		.wb_valid  (wb_valid),
		.wb_reg    (wb_reg),
		.wb_data   (wb_data)
	);

	core_checker core_checker_inst (
		.clk       (clk),
		.arst_n    (arst_n),
		.imem_addr (imem_addr),
		.wb_valid  (wb_valid),
		.wb_reg    (wb_reg),
		.wb_data   (wb_data)
	);

	function automatic logic [7:0] next_imm();
		next_imm = 8'($random(seed));
	endfunction

	// Appends one instruction and runs the reference model on it
	task automatic add_insn(input string name, input logic [3:0] opc, input reg_idx_t rd,
		input logic [7:0] low, input bit shadow);
		data_t a;
		data_t b;
		data_t res;
		logic  writes;
		a      = model_regs[low[7:4]];
		b      = model_regs[low[3:0]];
		res    = '0;
		writes = !shadow;              // Jump shadow never reaches writeback
		case (opc)
			`OP_MOVI: res = {8'h00, low};
			`OP_ADD:  res = a + b;
			`OP_SUB:  res = a - b;
			`OP_AND:  res = a & b;
			`OP_OR:   res = a | b;
			`OP_XOR:  res = a ^ b;
			default:  writes = 1'b0;
		endcase
		t_name[n_entries]    = name;
		t_insn[n_entries]    = {opc, rd, low};
		t_writes[n_entries]  = writes;
		t_exp_reg[n_entries] = rd;
		t_exp_val[n_entries] = res;
		if (writes) begin
			model_regs[rd] = res;
			n_writes++;
		end
		n_entries++;
	endtask

	task automatic finish_run(input bit late);
		$display("Writes seen %0d, expected %0d, errors %0d",
			core_checker_inst.write_count, n_writes, core_checker_inst.errors);
		if (core_checker_inst.errors == 0 && !late) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	endtask

	initial begin
		int waited;
		seed = 32'h9d79;
		for (int i = 0; i < 256; i++) begin
			rom[i] = {1'b1, i[7:0], i[6:0]};   // Opcodes 8 to 15 run as NOP
		end
		for (int i = 0; i < 16; i++) begin
			model_regs[i] = '0;
		end

		add_insn("movi_r1",   `OP_MOVI, 4'd1,  next_imm(), 1'b0);
		add_insn("movi_r2",   `OP_MOVI, 4'd2,  next_imm(), 1'b0);
		add_insn("movi_r3",   `OP_MOVI, 4'd3,  next_imm(), 1'b0);
		add_insn("add_r4",    `OP_ADD,  4'd4,  8'h12, 1'b0);
		add_insn("sub_wrap",  `OP_SUB,  4'd5,  8'h01, 1'b0);   // r0 - r1 goes negative
		add_insn("and_r6",    `OP_AND,  4'd6,  8'h43, 1'b0);
		add_insn("or_r7",     `OP_OR,   4'd7,  8'h52, 1'b0);
		add_insn("xor_r8",    `OP_XOR,  4'd8,  8'h67, 1'b0);
		add_insn("fwd_dist1", `OP_ADD,  4'd9,  8'h88, 1'b0);
		add_insn("fwd_dist2", `OP_ADD,  4'd10, 8'h89, 1'b0);
		add_insn("nop",       `OP_NOP,  4'd0,  8'h00, 1'b0);
		add_insn("fwd_nop",   `OP_SUB,  4'd9,  8'h9a, 1'b0);
		add_insn("jmp_fwd",   `OP_JMP,  4'd0,  8'(n_entries + 3), 1'b0);
		add_insn("shadow_1",  `OP_MOVI, 4'd11, 8'haa, 1'b1);
		add_insn("shadow_2",  `OP_ADD,  4'd12, 8'h11, 1'b1);
		add_insn("jmp_land",  `OP_XOR,  4'd13, 8'h91, 1'b0);
		add_insn("movi_r14",  `OP_MOVI, 4'd14, next_imm(), 1'b0);
		add_insn("self_jmp",  `OP_JMP,  4'd0,  8'(n_entries), 1'b0);

		for (int i = 0; i < n_entries; i++) begin
			rom[i] = t_insn[i];
			if (t_writes[i]) begin
				core_checker_inst.expect_write(t_name[i], t_exp_reg[i], t_exp_val[i]);
			end
		end

		repeat (4) @(negedge clk);
		arst_n <= 1'b1;

		waited = 0;
		while (core_checker_inst.write_count < n_writes && waited < 300) begin
			@(negedge clk);
			waited++;
		end
		if (core_checker_inst.write_count < n_writes) begin
			$display("Timeout: expected writes did not all arrive within 300 cycles");
			timed_out = 1'b1;
		end else begin
			for (int i = 0; i < 20; i++) begin
				@(negedge clk);             // Window for stray writes
			end
		end
		core_checker_inst.report_missing();
		finish_run(timed_out);
	end

endmodule

// ==== flist.f ====
+incdir+source
source/core_pkg.sv
source/core_ifs.sv
source/fetch_stage.sv
source/decode_stage.sv
source/reg_file.sv
source/execute_stage.sv
source/tiny_core.sv
sim/core_checker.sv
sim/tb_core.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds and runs the tiny_core testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f flist.f --top-module tb_core -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vtb_core > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Simulation FAILED" "$LOG"; then
	exit 1
fi
exit 0
